/* hw/bus_pkg.sv */
package bus_pkg;

    localparam int XLEN = 64;

    // address map
    localparam logic [XLEN-1:0] RAM_BASE       = 64'h0000_0000_8000_0000;
    localparam logic [XLEN-1:0] MTIME_ADDR     = 64'h0000_0000_0200_BFF8;
    localparam logic [XLEN-1:0] MTIMECMP_ADDR  = 64'h0000_0000_0200_4000;
    localparam logic [XLEN-1:0] PLIC_BASE      = 64'h0000_0000_0C00_0000;
    localparam logic [XLEN-1:0] PLIC_PENDING   = PLIC_BASE + 64'h1000;
    localparam logic [XLEN-1:0] PLIC_ENABLE    = PLIC_BASE + 64'h2000;
    localparam logic [XLEN-1:0] PLIC_THRESHOLD = PLIC_BASE + 64'h20_0000;
    localparam logic [XLEN-1:0] PLIC_CLAIM     = PLIC_BASE + 64'h20_0004;

    // per-context strides, enables and threshold/claim
    localparam logic [XLEN-1:0] PLIC_CTX_STRIDE_EN = 64'h80;
    localparam logic [XLEN-1:0] PLIC_CTX_STRIDE    = 64'h1000;

    // load/store codes, same as funct3
    localparam logic [2:0] LS_B  = 3'd0;
    localparam logic [2:0] LS_H  = 3'd1;
    localparam logic [2:0] LS_W  = 3'd2;
    localparam logic [2:0] LS_D  = 3'd3;
    localparam logic [2:0] LS_BU = 3'd4;
    localparam logic [2:0] LS_HU = 3'd5;
    localparam logic [2:0] LS_WU = 3'd6;

    // interrupt controller
    localparam int NUM_IRQ_SRC = 6;
    localparam int IRQ_ID_EXT  = 1;
    localparam int PRIO_W      = 3;

    localparam logic [XLEN-1:0] MTIMECMP_RESET = 64'h0000_0000_8000_0000;

    // read word, whole or as two 32-bit halves (low word first)
    typedef union packed {
        logic [XLEN-1:0]  dword;
        logic [1:0][31:0] word;
    } bus_word_u;

endpackage

/* hw/bus_ctrl.sv */
module bus_ctrl #(
    parameter int RAM_WORDS = 512
) (
    input  logic                      clock_slow,
    input  logic                      KEY0,
    input  logic [bus_pkg::XLEN-1:0]  bus_address,
    input  logic [2:0]                bus_ls_type,
    input  logic                      bus_read_enable,
    input  logic                      bus_write_enable,
    output bus_pkg::bus_word_u        bus_read_data,
    output logic                      bus_read_done,
    output logic                      bus_write_done,
    output logic                      ram_rd,
    output logic                      ram_wr,
    output logic                      ram_hi,
    output logic                      plic_rd,
    output logic                      plic_wr,
    output logic                      tmr_rd,
    output logic                      tmr_wr,
    input  logic [31:0]               ram_rdata,
    input  logic [31:0]               plic_rdata,
    input  logic [bus_pkg::XLEN-1:0]  tmr_rdata
);
    import bus_pkg::*;

    localparam logic [XLEN-1:0] RAM_END  = RAM_BASE + XLEN'(4 * RAM_WORDS);
    localparam logic [XLEN-1:0] PLIC_END = PLIC_CLAIM + PLIC_CTX_STRIDE + 64'd4;

    localparam logic [1:0] RGN_NONE = 2'd0;
    localparam logic [1:0] RGN_RAM  = 2'd1;
    localparam logic [1:0] RGN_PLIC = 2'd2;
    localparam logic [1:0] RGN_TMR  = 2'd3;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_TAKE = 2'd2;
    localparam logic [1:0] ST_NONE = 2'd3;

    logic [1:0] state;
    logic [1:0] rgn;
    logic [1:0] rgn_q;
    logic       is_rd;

    always_comb begin
        if (bus_address >= RAM_BASE && bus_address < RAM_END) begin
            rgn = RGN_RAM;
        end else if (bus_address >= PLIC_BASE && bus_address < PLIC_END) begin
            rgn = RGN_PLIC;
        end else if (bus_address == MTIME_ADDR || bus_address == MTIMECMP_ADDR) begin
            rgn = RGN_TMR;
        end else begin
            rgn = RGN_NONE;
        end
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            state          <= ST_IDLE;
            rgn_q          <= RGN_NONE;
            is_rd          <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            ram_rd         <= 1'b0;
            ram_wr         <= 1'b0;
            ram_hi         <= 1'b0;
            plic_rd        <= 1'b0;
            plic_wr        <= 1'b0;
            tmr_rd         <= 1'b0;
            tmr_wr         <= 1'b0;
        end else begin
            // strobes are single cycle
            ram_rd  <= 1'b0;
            ram_wr  <= 1'b0;
            plic_rd <= 1'b0;
            plic_wr <= 1'b0;
            tmr_rd  <= 1'b0;
            tmr_wr  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (bus_read_enable || bus_write_enable) begin
                        is_rd          <= bus_read_enable;
                        rgn_q          <= rgn;
                        bus_read_done  <= !bus_read_enable;
                        bus_write_done <= !bus_write_enable;
                        ram_rd         <= bus_read_enable && rgn == RGN_RAM;
                        ram_wr         <= bus_write_enable && rgn == RGN_RAM;
                        plic_rd        <= bus_read_enable && rgn == RGN_PLIC;
                        plic_wr        <= bus_write_enable && rgn == RGN_PLIC;
                        tmr_rd         <= bus_read_enable && rgn == RGN_TMR;
                        tmr_wr         <= bus_write_enable && rgn == RGN_TMR;
                        state          <= (rgn == RGN_NONE) ? ST_NONE : ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    state <= ST_TAKE;
                end
                ST_TAKE: begin
                    // ld/sd go round again for the upper word
                    if (rgn_q == RGN_RAM && bus_ls_type == LS_D && !ram_hi) begin
                        ram_hi <= 1'b1;
                        ram_rd <= is_rd;
                        ram_wr <= !is_rd;
                        state  <= ST_WAIT;
                    end else begin
                        ram_hi         <= 1'b0;
                        bus_read_done  <= 1'b1;
                        bus_write_done <= 1'b1;
                        state          <= ST_IDLE;
                    end
                end
                default: begin
                    bus_read_done  <= 1'b1;
                    bus_write_done <= 1'b1;
                    state          <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock_slow) begin
        if (state == ST_NONE && is_rd) begin
            bus_read_data.dword <= '0;
        end
        if (state == ST_TAKE && is_rd) begin
            case (rgn_q)
                RGN_RAM: begin
                    if (ram_hi) begin
                        bus_read_data.word[1] <= ram_rdata;
                    end else begin
                        bus_read_data.word[0] <= ram_rdata;
                        // codes 0..2 are signed loads
                        bus_read_data.word[1] <= {32{!bus_ls_type[2] && ram_rdata[31]}};
                    end
                end
                RGN_PLIC: bus_read_data.dword <= {32'd0, plic_rdata};
                RGN_TMR:  bus_read_data.dword <= tmr_rdata;
                default:  bus_read_data.dword <= '0;
            endcase
        end
    end

    // the CPU waits for both done flags before the next access
    a_no_strobe_busy: assert property (@(posedge clock_slow) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) |-> (bus_read_done && bus_write_done));

    a_one_direction: assert property (@(posedge clock_slow) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

endmodule

/* hw/local_ram.sv */
module local_ram #(
    parameter int RAM_WORDS = 512
) (
    input  logic                      clock_slow,
    input  logic [bus_pkg::XLEN-1:0]  bus_address,
    input  logic [2:0]                bus_ls_type,
    input  logic [bus_pkg::XLEN-1:0]  bus_write_data,
    input  logic                      ram_rd,
    input  logic                      ram_wr,
    input  logic                      ram_hi,
    output logic [31:0]               ram_rdata
);
    import bus_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]     mem [RAM_WORDS];
    logic [XLEN-1:0] byte_off;
    logic [AW-1:0]   idx;
    logic [1:0]      lane;
    logic [3:0]      be;
    logic [31:0]     wdata;
    logic [31:0]     shifted;
    logic [31:0]     ext;

    assign byte_off = bus_address - RAM_BASE;
    assign idx      = byte_off[AW+1:2] + AW'(ram_hi);
    assign lane     = bus_address[1:0];

    // byte lanes for the write
    always_comb begin
        wdata = bus_write_data[31:0];
        be    = 4'b1111;
        if (ram_hi) begin
            wdata = bus_write_data[63:32];
        end else if (bus_ls_type == LS_B) begin
            wdata = {4{bus_write_data[7:0]}};
            be    = 4'b0001 << lane;
        end else if (bus_ls_type == LS_H) begin
            wdata = {2{bus_write_data[15:0]}};
            be    = lane[1] ? 4'b1100 : 4'b0011;
        end
    end

    // align the addressed byte down, then extend
    always_comb begin
        shifted = mem[idx] >> {lane, 3'b000};
        case (bus_ls_type)
            LS_B:    ext = {{24{shifted[7]}}, shifted[7:0]};
            LS_BU:   ext = {24'd0, shifted[7:0]};
            LS_H:    ext = {{16{shifted[15]}}, shifted[15:0]};
            LS_HU:   ext = {16'd0, shifted[15:0]};
            default: ext = shifted;
        endcase
    end

    always_ff @(posedge clock_slow) begin
        if (ram_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (ram_rd) begin
            ram_rdata <= ext;
        end
    end

    a_half_aligned: assert property (@(posedge clock_slow)
        (ram_rd || ram_wr) && (bus_ls_type == LS_H || bus_ls_type == LS_HU)
        |-> !bus_address[0]);

    a_word_aligned: assert property (@(posedge clock_slow)
        (ram_rd || ram_wr)
        && (bus_ls_type == LS_W || bus_ls_type == LS_WU || bus_ls_type == LS_D)
        |-> bus_address[1:0] == 2'b00);

endmodule

/* hw/plic_regs.sv */
module plic_regs (
    input  logic                      clock_slow,
    input  logic                      KEY0,
    input  logic [bus_pkg::XLEN-1:0]  bus_address,
    input  logic [31:0]               bus_write_data,
    input  logic                      plic_rd,
    input  logic                      plic_wr,
    input  logic                      ext_irq,
    output logic [31:0]               plic_rdata,
    output logic                      meip_interrupt,
    output logic                      seip_interrupt
);
    import bus_pkg::*;

    localparam int SW = $clog2(NUM_IRQ_SRC);

    logic [PRIO_W-1:0] prio [NUM_IRQ_SRC];
    logic [31:0]       pending;
    logic [31:0]       enable [2];
    logic [PRIO_W-1:0] threshold [2];
    logic [31:0]       claim_id [2];
    logic              ext_irq_q;
    logic [XLEN-1:0]   off;
    logic [SW-1:0]     prio_idx;
    logic              sel_prio;
    logic              sel_pend;
    logic [1:0]        sel_en;
    logic [1:0]        sel_thr;
    logic [1:0]        sel_clm;
    logic [31:0]       rd_mux;

    assign off      = bus_address - PLIC_BASE;
    assign prio_idx = off[2 +: SW];
    assign sel_prio = bus_address >= PLIC_BASE && off < XLEN'(4 * NUM_IRQ_SRC);
    assign sel_pend = bus_address == PLIC_PENDING;

    always_comb begin
        rd_mux = sel_prio ? 32'(prio[prio_idx]) : '0;
        if (sel_pend) begin
            rd_mux = pending;
        end
        for (int c = 0; c < 2; c++) begin
            sel_en[c]  = bus_address == PLIC_ENABLE + c * PLIC_CTX_STRIDE_EN;
            sel_thr[c] = bus_address == PLIC_THRESHOLD + c * PLIC_CTX_STRIDE;
            sel_clm[c] = bus_address == PLIC_CLAIM + c * PLIC_CTX_STRIDE;
            // only the external source can be claimed
            claim_id[c] = (pending[IRQ_ID_EXT] && enable[c][IRQ_ID_EXT]) ? IRQ_ID_EXT : 0;
            if (sel_en[c]) begin
                rd_mux = enable[c];
            end
            if (sel_thr[c]) begin
                rd_mux = 32'(threshold[c]);
            end
            if (sel_clm[c]) begin
                rd_mux = claim_id[c];
            end
        end
    end

    assign meip_interrupt = claim_id[0] != 0;
    assign seip_interrupt = claim_id[1] != 0;

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            pending   <= '0;
            ext_irq_q <= 1'b0;
            enable    <= '{default: '0};
            threshold <= '{default: '0};
            prio      <= '{default: '0};
        end else begin
            ext_irq_q <= ext_irq;
            if (plic_wr && sel_prio) begin
                prio[prio_idx] <= bus_write_data[PRIO_W-1:0];
            end
            for (int c = 0; c < 2; c++) begin
                if (plic_wr && sel_en[c]) begin
                    enable[c] <= bus_write_data;
                end
                if (plic_wr && sel_thr[c]) begin
                    threshold[c] <= bus_write_data[PRIO_W-1:0];
                end
                // reading the claim register takes the interrupt
                if (plic_rd && sel_clm[c] && claim_id[c] != 0) begin
                    pending[IRQ_ID_EXT] <= 1'b0;
                end
            end
            if (ext_irq && !ext_irq_q) begin
                pending[IRQ_ID_EXT] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_slow) begin
        if (plic_rd) begin
            plic_rdata <= rd_mux;
        end
    end

endmodule

/* hw/timer_regs.sv */
module timer_regs (
    input  logic                      clock_slow,
    input  logic                      KEY0,
    input  logic [bus_pkg::XLEN-1:0]  bus_address,
    input  logic [bus_pkg::XLEN-1:0]  bus_write_data,
    input  logic                      tmr_rd,
    input  logic                      tmr_wr,
    input  logic [bus_pkg::XLEN-1:0]  mtime,
    output logic [bus_pkg::XLEN-1:0]  tmr_rdata,
    output logic                      mtip_interrupt
);
    import bus_pkg::*;

    logic [XLEN-1:0] mtimecmp;

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            mtimecmp <= MTIMECMP_RESET;
        end else if (tmr_wr && bus_address == MTIMECMP_ADDR) begin
            mtimecmp <= bus_write_data;
        end
    end

    // mtime itself lives outside and is read only here
    always_ff @(posedge clock_slow) begin
        if (tmr_rd) begin
            tmr_rdata <= (bus_address == MTIME_ADDR) ? mtime : mtimecmp;
        end
    end

    assign mtip_interrupt = mtime >= mtimecmp;

endmodule

/* hw/soc_bus.sv */
module soc_bus #(
    parameter int RAM_WORDS = 512
) (
    input  logic                      clock_slow,
    input  logic                      KEY0,
    input  logic [bus_pkg::XLEN-1:0]  bus_address,
    input  logic [2:0]                bus_ls_type,
    input  logic [bus_pkg::XLEN-1:0]  bus_write_data,
    input  logic                      bus_read_enable,
    input  logic                      bus_write_enable,
    output logic [bus_pkg::XLEN-1:0]  bus_read_data,
    output logic                      bus_read_done,
    output logic                      bus_write_done,
    input  logic [bus_pkg::XLEN-1:0]  mtime,
    input  logic                      ext_irq,
    output logic                      meip_interrupt,
    output logic                      seip_interrupt,
    output logic                      mtip_interrupt
);

    logic                     ram_rd;
    logic                     ram_wr;
    logic                     ram_hi;
    logic                     plic_rd;
    logic                     plic_wr;
    logic                     tmr_rd;
    logic                     tmr_wr;
    logic [31:0]              ram_rdata;
    logic [31:0]              plic_rdata;
    logic [bus_pkg::XLEN-1:0] tmr_rdata;

    bus_ctrl #(
        .RAM_WORDS(RAM_WORDS)
    ) bus_ctrl_i (
        .bus_read_data(bus_read_data),
        .*
    );

    local_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) local_ram_i (
        .*
    );

    // registers of the interrupt controller are 32 bits wide
    plic_regs plic_regs_i (
        .bus_write_data(bus_write_data[31:0]),
        .*
    );

    timer_regs timer_regs_i (
        .*
    );

endmodule

/* verif/tb_soc_bus.sv */
module tb_soc_bus;
    timeunit 1ns;
    timeprecision 100ps;
    import bus_pkg::*;

    localparam int N_INIT       = 16;
    localparam int N_NARROW     = 48;
    localparam int NUM_ACCESSES = N_INIT + 2 * N_NARROW + 48;

    logic              clock_slow;
    logic              KEY0;
    logic [XLEN-1:0]   bus_address;
    logic [2:0]        bus_ls_type;
    logic [XLEN-1:0]   bus_write_data;
    logic              bus_read_enable;
    logic              bus_write_enable;
    logic [XLEN-1:0]   bus_read_data;
    logic              bus_read_done;
    logic              bus_write_done;
    logic [XLEN-1:0]   mtime;
    logic              ext_irq;
    logic              meip_interrupt;
    logic              seip_interrupt;
    logic              mtip_interrupt;

    logic [31:0]       seed;
    logic [31:0]       shadow_ram [512];
    logic [XLEN-1:0]   shadow_mtimecmp;
    logic [PRIO_W-1:0] shadow_prio [NUM_IRQ_SRC];
    logic [31:0]       shadow_pending;
    logic [31:0]       shadow_en [2];
    logic [PRIO_W-1:0] shadow_thr [2];
    string             cmp_name [$];
    logic [XLEN-1:0]   cmp_exp [$];
    logic [XLEN-1:0]   cmp_act [$];

    soc_bus #(
        .RAM_WORDS(512)
    ) soc_bus_i (
        .*
    );

    always #50 clock_slow = ~clock_slow;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed ^ (seed >> 16);
    endfunction

    function automatic logic is_ram(logic [XLEN-1:0] addr);
        return addr >= RAM_BASE && addr < RAM_BASE + 64'd2048;
    endfunction

    function automatic logic is_prio(logic [XLEN-1:0] addr);
        return addr >= PLIC_BASE && addr < PLIC_BASE + XLEN'(4 * NUM_IRQ_SRC);
    endfunction

    function automatic logic expected_irq(int ctx);
        return shadow_pending[IRQ_ID_EXT] && shadow_en[ctx][IRQ_ID_EXT];
    endfunction

    // shadow update for every write the bus accepts
    function automatic void model_write(logic [XLEN-1:0] addr, logic [2:0] ls,
                                        logic [XLEN-1:0] data);
        int w;
        int lane;
        w = int'((addr - RAM_BASE) >> 2);
        lane = int'(addr[1:0]);
        if (is_ram(addr)) begin
            case (ls)
                LS_B: shadow_ram[w][8*lane +: 8] = data[7:0];
                LS_H: shadow_ram[w][8*lane +: 16] = data[15:0];
                LS_D: begin
                    shadow_ram[w] = data[31:0];
                    shadow_ram[w + 1] = data[63:32];
                end
                default: shadow_ram[w] = data[31:0];
            endcase
        end else if (addr == MTIMECMP_ADDR) begin
            shadow_mtimecmp = data;
        end else if (is_prio(addr)) begin
            shadow_prio[int'((addr - PLIC_BASE) >> 2)] = data[PRIO_W-1:0];
        end
        for (int c = 0; c < 2; c++) begin
            if (addr == PLIC_ENABLE + XLEN'(c) * PLIC_CTX_STRIDE_EN) begin
                shadow_en[c] = data[31:0];
            end
            if (addr == PLIC_THRESHOLD + XLEN'(c) * PLIC_CTX_STRIDE) begin
                shadow_thr[c] = data[PRIO_W-1:0];
            end
        end
    endfunction

    // expected read value; a claim also takes the pending bit
    function automatic logic [XLEN-1:0] expected_read(logic [XLEN-1:0] addr, logic [2:0] ls);
        int              w;
        logic [31:0]     word;
        logic [XLEN-1:0] r;
        r = '0;
        if (is_ram(addr)) begin
            w = int'((addr - RAM_BASE) >> 2);
            word = shadow_ram[w] >> (8 * addr[1:0]);
            case (ls)
                LS_B:    r = {{56{word[7]}}, word[7:0]};
                LS_BU:   r = {56'd0, word[7:0]};
                LS_H:    r = {{48{word[15]}}, word[15:0]};
                LS_HU:   r = {48'd0, word[15:0]};
                LS_W:    r = {{32{word[31]}}, word};
                LS_WU:   r = {32'd0, word};
                default: r = {shadow_ram[w + 1], shadow_ram[w]};
            endcase
        end else if (addr == MTIME_ADDR) begin
            r = mtime;
        end else if (addr == MTIMECMP_ADDR) begin
            r = shadow_mtimecmp;
        end else if (is_prio(addr)) begin
            r = XLEN'(shadow_prio[int'((addr - PLIC_BASE) >> 2)]);
        end else if (addr == PLIC_PENDING) begin
            r = XLEN'(shadow_pending);
        end
        for (int c = 0; c < 2; c++) begin
            if (addr == PLIC_ENABLE + XLEN'(c) * PLIC_CTX_STRIDE_EN) begin
                r = XLEN'(shadow_en[c]);
            end
            if (addr == PLIC_THRESHOLD + XLEN'(c) * PLIC_CTX_STRIDE) begin
                r = XLEN'(shadow_thr[c]);
            end
            if (addr == PLIC_CLAIM + XLEN'(c) * PLIC_CTX_STRIDE && expected_irq(c)) begin
                r = XLEN'(IRQ_ID_EXT);
                shadow_pending[IRQ_ID_EXT] = 1'b0;
            end
        end
        return r;
    endfunction

    // byte offset inside a word that suits the access width
    function automatic logic [XLEN-1:0] lane_offset(logic [1:0] off, logic [2:0] ls);
        if (ls == LS_B || ls == LS_BU) begin
            return XLEN'(off);
        end else if (ls == LS_H || ls == LS_HU) begin
            return XLEN'({off[1], 1'b0});
        end
        return '0;
    endfunction

    function automatic logic [2:0] load_code(int k);
        case (k % 6)
            0:       return LS_B;
            1:       return LS_H;
            2:       return LS_W;
            3:       return LS_BU;
            4:       return LS_HU;
            default: return LS_WU;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic post_compare(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        cmp_name.push_back(name);
        cmp_exp.push_back(exp);
        cmp_act.push_back(act);
    endtask

    // compare process, drains what the stimulus has collected
    always @(posedge clock_slow) begin
        while (cmp_name.size() > 0) begin
            check_value(cmp_name.pop_front(), cmp_exp.pop_front(), cmp_act.pop_front());
        end
    end

    task automatic bus_write(input logic [XLEN-1:0] addr, input logic [2:0] ls,
                             input logic [XLEN-1:0] data);
        model_write(addr, ls, data);
        bus_address = addr;
        bus_ls_type = ls;
        bus_write_data = data;
        bus_write_enable = 1'b1;
        @(posedge clock_slow);
        #1;
        bus_write_enable = 1'b0;
        while (!bus_write_done) begin
            @(posedge clock_slow);
            #1;
        end
    endtask

    task automatic read_compare(input string name, input logic [XLEN-1:0] addr,
                                input logic [2:0] ls);
        logic [XLEN-1:0] exp;
        exp = expected_read(addr, ls);
        bus_address = addr;
        bus_ls_type = ls;
        bus_read_enable = 1'b1;
        @(posedge clock_slow);
        #1;
        bus_read_enable = 1'b0;
        while (!bus_read_done) begin
            @(posedge clock_slow);
            #1;
        end
        post_compare(name, exp, bus_read_data);
    endtask

    // interrupt lines, one clock after the inputs changed
    task automatic check_irqs(input string name);
        @(posedge clock_slow);
        #1;
        post_compare(name,
                     XLEN'({expected_irq(0), expected_irq(1), mtime >= shadow_mtimecmp}),
                     XLEN'({meip_interrupt, seip_interrupt, mtip_interrupt}));
    endtask

    task automatic pulse_ext_irq();
        ext_irq = 1'b1;
        shadow_pending[IRQ_ID_EXT] = 1'b1;
        @(posedge clock_slow);
        #1;
        ext_irq = 1'b0;
    endtask

    initial begin
        logic [XLEN-1:0] base;
        logic [2:0]      st;
        logic [2:0]      ld;
        logic [1:0]      off;
        clock_slow = 1'b0;
        KEY0 = 1'b0;
        bus_address = '0;
        bus_ls_type = LS_W;
        bus_write_data = '0;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        mtime = '0;
        ext_irq = 1'b0;
        seed = 32'd2;
        shadow_mtimecmp = MTIMECMP_RESET;
        shadow_pending = '0;
        shadow_en = '{default: '0};
        shadow_thr = '{default: '0};
        shadow_prio = '{default: '0};
        repeat (16) @(posedge clock_slow);
        #1;
        KEY0 = 1'b1;
        @(posedge clock_slow);
        #1;
        post_compare("done_after_reset", 64'd3, XLEN'({bus_read_done, bus_write_done}));
        check_irqs("irq_after_reset");

        // fill a few words so every narrow load sees known bytes
        for (int i = 0; i < N_INIT; i++) begin
            bus_write(RAM_BASE + XLEN'(4 * i), LS_W, XLEN'(lcg_next()));
        end
        for (int i = 0; i < N_NARROW; i++) begin
            base = RAM_BASE + XLEN'(4 * (lcg_next() % N_INIT));
            st = (lcg_next() % 3 == 0) ? LS_B : (lcg_next() % 2 == 0) ? LS_H : LS_W;
            ld = load_code(i);
            off = lcg_next() % 4;
            bus_write(base + lane_offset(off, st), st, {lcg_next(), lcg_next()});
            read_compare($sformatf("narrow_load_%0d", i), base + lane_offset(off, ld), ld);
        end

        base = RAM_BASE + 64'd400;
        bus_write(base, LS_D, {lcg_next(), lcg_next()});
        read_compare("ld_after_sd", base, LS_D);
        read_compare("lw_low_half", base, LS_W);
        read_compare("lw_high_half", base + 64'd4, LS_W);

        read_compare("mtimecmp_reset", MTIMECMP_ADDR, LS_D);
        bus_write(MTIMECMP_ADDR, LS_D, 64'd5000);
        read_compare("mtimecmp_written", MTIMECMP_ADDR, LS_D);
        mtime = 64'd4999;
        check_irqs("mtip_below");
        mtime = 64'd5000;
        check_irqs("mtip_equal");
        read_compare("mtime_read", MTIME_ADDR, LS_D);
        bus_write(MTIMECMP_ADDR, LS_D, {lcg_next(), lcg_next()});
        check_irqs("mtip_new_compare");

        for (int i = 1; i < NUM_IRQ_SRC; i++) begin
            bus_write(PLIC_BASE + XLEN'(4 * i), LS_W, XLEN'(lcg_next()));
            read_compare($sformatf("priority_%0d", i), PLIC_BASE + XLEN'(4 * i), LS_W);
        end
        for (int c = 0; c < 2; c++) begin
            base = PLIC_ENABLE + XLEN'(c) * PLIC_CTX_STRIDE_EN;
            bus_write(base, LS_W, XLEN'(lcg_next() & ~32'h2));
            read_compare($sformatf("enable_ctx%0d", c), base, LS_W);
            base = PLIC_THRESHOLD + XLEN'(c) * PLIC_CTX_STRIDE;
            bus_write(base, LS_W, XLEN'(lcg_next()));
            read_compare($sformatf("threshold_ctx%0d", c), base, LS_W);
        end

        pulse_ext_irq();
        read_compare("pending_after_edge", PLIC_PENDING, LS_W);
        check_irqs("irq_not_enabled");
        bus_write(PLIC_ENABLE, LS_W, 64'h2);
        check_irqs("meip_enabled");
        read_compare("claim_ctx0", PLIC_CLAIM, LS_W);
        check_irqs("meip_claimed");
        read_compare("pending_after_claim", PLIC_PENDING, LS_W);
        bus_write(PLIC_ENABLE, LS_W, 64'h0);
        bus_write(PLIC_ENABLE + PLIC_CTX_STRIDE_EN, LS_W, 64'h2);
        pulse_ext_irq();
        check_irqs("seip_enabled");
        read_compare("claim_ctx1", PLIC_CLAIM + PLIC_CTX_STRIDE, LS_W);
        check_irqs("seip_claimed");

        read_compare("unmapped_read", 64'h0000_0000_4000_0000, LS_W);

        repeat (2) @(posedge clock_slow);
        #1;
        $display("Everything OK");
        $finish;
    end

    initial begin
        repeat (NUM_ACCESSES * 10 + 1000) @(posedge clock_slow);
        $display("timeout: the bus accesses did not finish in time");
        $display("Something failed");
        $fatal(1);
    end

endmodule

/* flist.f */
hw/bus_pkg.sv
hw/bus_ctrl.sv
hw/local_ram.sv
hw/plic_regs.sv
hw/timer_regs.sv
hw/soc_bus.sv
verif/tb_soc_bus.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_bus \
    -f flist.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation failed (exit status $status)"
    exit 1
fi
echo "simulation passed"
